/* simd_pkg.sv */
// SIMD unit shared package with lane widths, opcodes and the packed pipeline stage types.
package simd_pkg;

  localparam int LANE_W = 32;         // Bits per lane.
  localparam int TAG_W  = 4;          // Issue tag width.
  localparam int VEC_W  = 2 * LANE_W; // Two lanes side by side.
  localparam int FLAG_W = 4;          // Two flags per lane.

  typedef logic [LANE_W-1:0] lane_t;  // One lane value.
  typedef logic [VEC_W-1:0]  vec_t;   // High lane in the upper half.
  typedef logic [TAG_W-1:0]  tag_t;   // Returned with the result.

  // Operations supported by both lanes.
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0, // Signed add per lane.
    OP_SUB  = 3'd1, // Signed subtract per lane.
    OP_MIN  = 3'd2, // Signed minimum.
    OP_MAX  = 3'd3, // Signed maximum.
    OP_SWAP = 3'd4, // Take the other lane's a.
    OP_HADD = 3'd5  // a_hi plus a_lo into both lanes.
  } op_e;

  // Request as it arrives at the unit.
  typedef struct packed {
    logic       valid;
    tag_t       tag;
    op_e        op;
    logic [1:0] en;    // Bit 1 enables the high lane.
    vec_t       a;
    vec_t       b;
  } issue_req_t;

  // Work item for a single lane.
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    op_e   op;
    logic  en;
    lane_t a;
    lane_t b;
    lane_t xa;         // Other lane's a, filled by the exchange stage.
  } lane_op_t;

  // Result of a single lane.
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    lane_t data;
    logic  ovf;
    logic  zero;
  } lane_res_t;

  // Merged result leaving the unit.
  typedef struct packed {
    logic              valid;
    tag_t              tag;
    vec_t              data;
    logic [FLAG_W-1:0] flags; // {ovf_hi, zero_hi, ovf_lo, zero_lo}.
  } vec_res_t;

endpackage

/* simd_issue.sv */
// SIMD issue stage that registers an incoming request and splits it into two lane work items.
`timescale 1ns/10ps

module simd_issue
  import simd_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  issue_req_t req,
  output lane_op_t   lane_hi,
  output lane_op_t   lane_lo
);

  lane_op_t hi_d;
  lane_op_t lo_d;

  // Split the operand words; both lanes carry the same tag and op.
  always_comb begin
    hi_d       = '0;
    hi_d.valid = req.valid;
    hi_d.tag   = req.tag;
    hi_d.op    = req.op;
    hi_d.en    = req.en[1];              // High lane enable.
    hi_d.a     = req.a[VEC_W-1:LANE_W];
    hi_d.b     = req.b[VEC_W-1:LANE_W];
    hi_d.xa    = '0;                     // Filled one stage later.

    lo_d       = '0;
    lo_d.valid = req.valid;
    lo_d.tag   = req.tag;
    lo_d.op    = req.op;
    lo_d.en    = req.en[0];              // Low lane enable.
    lo_d.a     = req.a[LANE_W-1:0];
    lo_d.b     = req.b[LANE_W-1:0];
    lo_d.xa    = '0;
  end

  // Stage register sampled at the edge where the request is taken.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_hi <= '0;
      lane_lo <= '0;
    end else begin
      lane_hi <= hi_d;
      lane_lo <= lo_d;
    end
  end

endmodule

/* simd_operand_xbar.sv */
// SIMD exchange stage that hands each lane the other lane's a operand.
`timescale 1ns/10ps

module simd_operand_xbar
  import simd_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  lane_op_t in_hi,
  input  lane_op_t in_lo,
  output lane_op_t out_hi,
  output lane_op_t out_lo
);

  lane_op_t hi_x;
  lane_op_t lo_x;

  // Crossed wiring between the two halves.
  always_comb begin
    hi_x    = in_hi;
    hi_x.xa = in_lo.a;   // High lane sees the low a.
    lo_x    = in_lo;
    lo_x.xa = in_hi.a;   // Low lane sees the high a.
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_hi <= '0;
      out_lo <= '0;
    end else begin
      out_hi <= hi_x;
      out_lo <= lo_x;
    end
  end

endmodule

/* simd_lane.sv */
// SIMD lane execute stage computing one lane's result with overflow and zero flags.
`timescale 1ns/10ps

module simd_lane
  import simd_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  lane_op_t  op_in,
  output lane_res_t res
);

  lane_t     addend;    // Second adder input.
  logic      carry_in;
  lane_t     sum;
  logic      sum_ovf;
  logic      a_lt_b;
  lane_t     data_raw;
  logic      ovf_raw;
  lane_res_t res_d;

  // One shared adder covers add, subtract and horizontal add.
  always_comb begin
    addend   = op_in.b;
    carry_in = 1'b0;
    case (op_in.op)
      OP_SUB: begin
        addend   = ~op_in.b;  // Two's complement negate.
        carry_in = 1'b1;
      end
      OP_HADD: addend = op_in.xa;
      default: addend = op_in.b;
    endcase
  end

  assign sum = op_in.a + addend + lane_t'(carry_in);

  // Same input signs but a different result sign.
  assign sum_ovf = (op_in.a[LANE_W-1] == addend[LANE_W-1]) &&
                   (sum[LANE_W-1] != op_in.a[LANE_W-1]);

  assign a_lt_b = $signed(op_in.a) < $signed(op_in.b);

  // Select the lane result by opcode.
  always_comb begin
    data_raw = '0;
    ovf_raw  = 1'b0;
    case (op_in.op)
      OP_ADD, OP_SUB, OP_HADD: begin
        data_raw = sum;
        ovf_raw  = sum_ovf;
      end
      OP_MIN:  data_raw = a_lt_b ? op_in.a : op_in.b;
      OP_MAX:  data_raw = a_lt_b ? op_in.b : op_in.a;
      OP_SWAP: data_raw = op_in.xa;
      default: begin
        data_raw = '0;
        ovf_raw  = 1'b0;
      end
    endcase
  end

  // A disabled lane returns all zeros but still carries valid and tag.
  always_comb begin
    res_d       = '0;
    res_d.valid = op_in.valid;
    res_d.tag   = op_in.tag;
    if (op_in.en) begin
      res_d.data = data_raw;
      res_d.ovf  = ovf_raw;
      res_d.zero = (data_raw == '0);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res <= '0;
    end else begin
      res <= res_d;
    end
  end

endmodule

/* simd_retire.sv */
// SIMD retire stage merging the two lane results into one registered vector result.
`timescale 1ns/10ps

module simd_retire
  import simd_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  lane_res_t res_hi,
  input  lane_res_t res_lo,
  output vec_res_t  out
);

  vec_res_t merged;

  // Both halves return the same valid and tag, so an OR joins them.
  always_comb begin
    merged       = '0;
    merged.valid = res_hi.valid | res_lo.valid;
    merged.tag   = res_hi.tag | res_lo.tag;
    merged.data  = {res_hi.data, res_lo.data};   // High lane on top.
    merged.flags = {res_hi.ovf, res_hi.zero,
                    res_lo.ovf, res_lo.zero};
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out <= '0;
    end else begin
      out <= merged;
    end
  end

endmodule

/* simd_unit.sv */
// Two-lane SIMD execution unit with issue, exchange, lane execute and retire stages.
`timescale 1ns/10ps

module simd_unit
  import simd_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  issue_req_t req,
  output vec_res_t   res
);

  lane_op_t  issue_hi;   // Issue to exchange.
  lane_op_t  issue_lo;
  lane_op_t  xbar_hi;    // Exchange to lanes.
  lane_op_t  xbar_lo;
  lane_res_t lane_res_hi;
  lane_res_t lane_res_lo;

  simd_issue u_issue (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .lane_hi (issue_hi),
    .lane_lo (issue_lo)
  );

  simd_operand_xbar u_xbar (
    .clk    (clk),
    .arst_n (arst_n),
    .in_hi  (issue_hi),
    .in_lo  (issue_lo),
    .out_hi (xbar_hi),
    .out_lo (xbar_lo)
  );

  // Same lane block for both halves.
  simd_lane u_lane_hi (
    .clk    (clk),
    .arst_n (arst_n),
    .op_in  (xbar_hi),
    .res    (lane_res_hi)
  );

  simd_lane u_lane_lo (
    .clk    (clk),
    .arst_n (arst_n),
    .op_in  (xbar_lo),
    .res    (lane_res_lo)
  );

  simd_retire u_retire (
    .clk    (clk),
    .arst_n (arst_n),
    .res_hi (lane_res_hi),
    .res_lo (lane_res_lo),
    .out    (res)
  );

endmodule

/* simd_clock_gen.sv */
// SIMD testbench clock and reset generator with a 100 ns clock and a four-cycle reset.
`timescale 1ns/10ps

module simd_clock_gen (
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD = 50; // Half of the 100 ns period.
  localparam int RST_CYCLES  = 4;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release just after the last reset edge.
  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

endmodule

/* simd_unit_properties.sv */
// SIMD unit port assertions for reset behavior, fixed latency and clean result data.
`timescale 1ns/10ps

module simd_unit_properties
  import simd_pkg::*;
(
  input logic       clk,
  input logic       arst_n,
  input issue_req_t req,
  input vec_res_t   res
);

  localparam int LATENCY = 4; // Four register stages.

  // Nothing retires while the unit is held in reset.
  a_no_valid_in_reset: assert property (
    @(posedge clk) !arst_n |-> !res.valid
  ) else $error("res.valid high while arst_n is low");

  // Each accepted request leaves exactly four cycles later.
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    $past(req.valid, LATENCY) |-> res.valid
  ) else $error("request not followed by a result four cycles later");

  // And no result shows up without a request behind it.
  a_no_spurious_result: assert property (
    @(posedge clk) disable iff (!arst_n)
    res.valid |-> $past(req.valid, LATENCY)
  ) else $error("result without a matching request four cycles earlier");

  a_data_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    res.valid |-> !$isunknown({res.tag, res.data, res.flags})
  ) else $error("unknown bits on a valid result");

endmodule

/* simd_unit_tb.sv */
// SIMD unit testbench with directed and random requests checked against a reference model.
`timescale 1ns/10ps

module simd_unit_tb
  import simd_pkg::*;
();

  localparam int          CLK_PERIOD   = 100;
  localparam int          NUM_DIRECTED = 17;
  localparam int          NUM_RANDOM   = 48;
  localparam int          NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
  localparam int          LATENCY      = 4;
  localparam logic [31:0] LFSR_SEED    = 32'h186c_82ba;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003; // Maximal length taps for a right shift.

  logic        clk;
  logic        arst_n;
  issue_req_t  req;
  vec_res_t    res;
  logic [31:0] lfsr;
  tag_t        next_tag;
  int          cycle;
  int          errors;
  int          checks;
  vec_res_t    exp_q[$];  // Expected results in issue order.
  int          cyc_q[$];  // Cycle at which each request was driven.

  simd_clock_gen u_clock_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  simd_unit u_simd_unit (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .res    (res)
  );

  bind simd_unit simd_unit_properties u_simd_unit_properties (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .res    (res)
  );

  always @(posedge clk) cycle <= cycle + 1;

  // Galois LFSR stepped once per bit taken.
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    logic        bit_out;
    val = '0;
    for (int k = 0; k < n; k++) begin
      bit_out = lfsr[0];
      lfsr    = {1'b0, lfsr[31:1]} ^ (bit_out ? LFSR_TAPS : 32'h0);
      val     = {val[62:0], bit_out};
    end
    return val;
  endfunction

  // Expected result of one lane from wide signed arithmetic for overflow.
  function automatic lane_res_t lane_expect(input op_e op, input logic en,
                                            input lane_t a, input lane_t b, input lane_t xa);
    lane_res_t r;
    longint    sa;
    longint    sb;
    longint    sx;
    longint    full;
    r    = '0;
    sa   = $signed(a);
    sb   = $signed(b);
    sx   = $signed(xa);
    full = 0;
    case (op)
      OP_ADD:  full = sa + sb;
      OP_SUB:  full = sa - sb;
      OP_HADD: full = sa + sx;
      default: full = 0;
    endcase
    case (op)
      OP_ADD, OP_SUB, OP_HADD: begin
        r.data = full[31:0];
        r.ovf  = (full > 64'sd2147483647) || (full < -64'sd2147483648);
      end
      OP_MIN:  r.data = (sa < sb) ? a : b;
      OP_MAX:  r.data = (sa > sb) ? a : b;
      OP_SWAP: r.data = xa;
      default: r.data = '0;
    endcase
    if (en) begin
      r.zero = (r.data == '0);
    end else begin
      r = '0; // Disabled lane returns nothing.
    end
    return r;
  endfunction

  function automatic vec_res_t simd_ref(input issue_req_t r);
    vec_res_t  e;
    lane_res_t hi;
    lane_res_t lo;
    hi = lane_expect(r.op, r.en[1], r.a[63:32], r.b[63:32], r.a[31:0]);
    lo = lane_expect(r.op, r.en[0], r.a[31:0], r.b[31:0], r.a[63:32]);
    e       = '0;
    e.valid = 1'b1;
    e.tag   = r.tag;
    e.data  = {hi.data, lo.data};
    e.flags = {hi.ovf, hi.zero, lo.ovf, lo.zero};
    return e;
  endfunction

  // Drive one request for a single cycle and record what should come back.
  task automatic send(input op_e op, input logic [1:0] en, input vec_t a, input vec_t b);
    issue_req_t r;
    r.valid = 1'b1;
    r.tag   = next_tag;
    r.op    = op;
    r.en    = en;
    r.a     = a;
    r.b     = b;
    req     = r;
    exp_q.push_back(simd_ref(r));
    cyc_q.push_back(cycle);
    next_tag = next_tag + 4'd1;
    @(posedge clk);
    #1;
  endtask

  task automatic send_random();
    logic [2:0] op_bits;
    logic [1:0] en_bits;
    vec_t       a;
    vec_t       b;
    op_bits = 3'(take_bits(3) % 64'd6);
    en_bits = 2'(take_bits(2));
    a       = take_bits(64);
    b       = take_bits(64);
    send(op_e'(op_bits), en_bits, a, b);
  endtask

  // Compare every valid result against the head of the queue.
  always @(negedge clk) begin : compare
    vec_res_t exp_res;
    int       issued;
    if (res.valid) begin
      if (exp_q.size() == 0) begin
        $display("Result with tag %h appeared while no request was outstanding", res.tag);
        errors++;
      end else begin
        exp_res = exp_q.pop_front();
        issued  = cyc_q.pop_front();
        checks++;
        if (res.tag !== exp_res.tag) begin
          $display("ERROR res.tag got %h expected %h", res.tag, exp_res.tag);
          errors++;
        end
        if (res.data !== exp_res.data) begin
          $display("ERROR res.data got %h expected %h", res.data, exp_res.data);
          errors++;
        end
        if (res.flags !== exp_res.flags) begin
          $display("ERROR res.flags got %h expected %h", res.flags, exp_res.flags);
          errors++;
        end
        if (cycle != issued + LATENCY) begin
          $display("Result with tag %h took %0d cycles instead of %0d",
                   res.tag, cycle - issued, LATENCY);
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    #((NUM_OPS + 20) * CLK_PERIOD);
    $display("Timeout with %0d results still outstanding", exp_q.size());
    errors++;
    $display("Result checks: %0d, errors: %0d", checks, errors);
    $display("Errors found");
    $finish;
  end

  initial begin
    req      = '0;
    lfsr     = LFSR_SEED;
    next_tag = '0;
    cycle    = 0;
    errors   = 0;
    checks   = 0;
    @(posedge arst_n);
    repeat (3) @(posedge clk); // Idle cycles where nothing may retire yet.
    #1;
    // Add and subtract with overflow on both lanes.
    send(OP_ADD, 2'b11, 64'h7fffffff_00000005, 64'h00000001_fffffffb);
    send(OP_ADD, 2'b11, 64'h80000000_00000001, 64'hffffffff_00000002);
    send(OP_SUB, 2'b11, 64'h80000000_7fffffff, 64'h00000001_ffffffff);
    send(OP_SUB, 2'b11, 64'h00000010_00000003, 64'h00000003_00000003);
    // Signed min and max with mixed signs.
    send(OP_MIN, 2'b11, 64'hfffffffb_00000003, 64'h00000003_fffffffb);
    send(OP_MAX, 2'b11, 64'hfffffffb_00000003, 64'h00000003_fffffffb);
    send(OP_MAX, 2'b11, 64'h00000000_80000000, 64'h00000000_7fffffff);
    send(OP_MIN, 2'b11, 64'h00000000_80000000, 64'hffffffff_7fffffff);
    // Cross-lane moves.
    send(OP_SWAP, 2'b11, 64'h11111111_22222222, 64'h33333333_44444444);
    send(OP_SWAP, 2'b11, 64'h00000000_12345678, 64'h0);
    send(OP_HADD, 2'b11, 64'h7fffffff_00000001, 64'h0);
    send(OP_HADD, 2'b11, 64'hfffffffd_00000003, 64'h0);
    // Partial enable masks.
    send(OP_ADD, 2'b00, 64'h00000001_00000002, 64'h00000003_00000004);
    send(OP_ADD, 2'b01, 64'h7fffffff_00000002, 64'h00000001_00000004);
    send(OP_SUB, 2'b10, 64'h00000009_00000002, 64'h00000004_00000002);
    send(OP_HADD, 2'b01, 64'h00000005_00000006, 64'h0);
    send(OP_SWAP, 2'b10, 64'habcdef01_00000000, 64'h0);
    // Back-to-back random traffic.
    for (int i = 0; i < NUM_RANDOM; i++) begin
      send_random();
    end
    req = '0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(posedge clk);
    $display("Result checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
simd_pkg.sv
simd_issue.sv
simd_operand_xbar.sv
simd_lane.sv
simd_retire.sv
simd_unit.sv
simd_clock_gen.sv
simd_unit_properties.sv
simd_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SIMD unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
  --top-module simd_unit_tb \
  -f build.f \
  -o simd_unit_sim

./obj_dir/simd_unit_sim | tee "$LOG"

if grep -qx "No errors" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
